// ==== hdl/c64_host_pkg.sv ====
////////////////////
// shared constants and types for the C64 host fabric
// address map, bus widths, region and joystick select enums
// imported by every RTL block of the fabric
////////////////////

package c64_host_pkg;

  //////////////////// bus widths

  localparam int CPU_AW     = 32;
  localparam int CPU_DW     = 32;
  localparam int CPU_STRB_W = 4;
  // byte lane index within a cpu word
  localparam int CPU_LANE_W = 2;

  localparam int C64_AW     = 16;
  localparam int C64_DW     = 8;

  localparam int KEY_W      = 16;
  // up, down, left, right, a
  localparam int JOY_W      = 5;
  localparam int CTRL_W     = 5;
  localparam int KBD_MASK_W = 64;

  //////////////////// address map

  // upper nibble for cont/ctrl, upper halfword for the loader
  localparam logic [3:0]  REGION_CONT   = 4'h2;
  localparam logic [3:0]  REGION_CTRL   = 4'h3;
  localparam logic [15:0] REGION_LOADER = 16'h5000;

  // word offsets in the control region
  localparam int CTRL_OFS_W = 2;
  localparam logic [CTRL_OFS_W-1:0] CTRL_OFS_MASK_LO = 2'd1;
  localparam logic [CTRL_OFS_W-1:0] CTRL_OFS_MASK_HI = 2'd2;
  localparam logic [CTRL_OFS_W-1:0] CTRL_OFS_CTRL    = 2'd3;

  // control word fields
  localparam int CTRL_RUN_BIT  = 0;
  localparam int CTRL_JOY1_LSB = 1;
  localparam int CTRL_JOY2_LSB = 3;

  typedef enum logic [1:0] {
    REG_NONE,
    REG_CONT,
    REG_CTRL,
    REG_LOADER
  } host_region_t;

  // code 3 is unused and acts like none
  typedef enum logic [1:0] {
    JOY_NONE  = 2'd0,
    JOY_CONT1 = 2'd1,
    JOY_CONT2 = 2'd2
  } joy_src_t;

endpackage

// ==== hdl/host_bus_decode.sv ====
////////////////////
// cpu bus slave decode for the host fabric
// classifies the address, raises write strobes for the
// control and loader blocks, and pulses ready per access
////////////////////

`timescale 1ns/100ps

module host_bus_decode (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_cpu_valid,
  input  logic [c64_host_pkg::CPU_AW-1:0]     i_cpu_addr,
  input  logic [c64_host_pkg::CPU_STRB_W-1:0] i_cpu_wstrb,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont1_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont2_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont3_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont4_key,
  input  logic [c64_host_pkg::CTRL_W-1:0]     i_c64_ctrl,
  input  logic                                i_loader_done,
  output logic                                o_cpu_ready,
  output logic [c64_host_pkg::CPU_DW-1:0]     o_cpu_rdata,
  output logic                                o_reg_wr,
  output logic                                o_loader_wr
);

  import c64_host_pkg::*;

  host_region_t              region;
  logic                      ofs_in_range;
  logic [CTRL_OFS_W-1:0]     word_ofs;

  //////////////////// region decode

  always_comb begin
    region = REG_NONE;
    if (i_cpu_addr[CPU_AW-1 -: $bits(REGION_LOADER)] == REGION_LOADER) begin
      region = REG_LOADER;
    end else if (i_cpu_addr[CPU_AW-1 -: $bits(REGION_CONT)] == REGION_CONT) begin
      region = REG_CONT;
    end else if (i_cpu_addr[CPU_AW-1 -: $bits(REGION_CTRL)] == REGION_CTRL) begin
      region = REG_CTRL;
    end
  end

  // registers only live in the first four words of a region
  assign ofs_in_range = (i_cpu_addr[CPU_AW-$bits(REGION_CONT)-1:CPU_LANE_W+CTRL_OFS_W] == '0);
  assign word_ofs     = i_cpu_addr[CPU_LANE_W +: CTRL_OFS_W];

  // full word writes only for the control registers
  assign o_reg_wr    = i_cpu_valid && (region == REG_CTRL) && ofs_in_range
                       && (i_cpu_wstrb == '1);
  assign o_loader_wr = i_cpu_valid && (region == REG_LOADER) && (i_cpu_wstrb != '0);

  //////////////////// completion

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cpu_ready <= 1'b0;
    end else begin
      case (region)
        REG_CONT, REG_CTRL: o_cpu_ready <= ~o_cpu_ready & i_cpu_valid;
        // waits for the ph2 hold to end
        REG_LOADER: o_cpu_ready <= ~o_cpu_ready & i_cpu_valid & i_loader_done;
        default: o_cpu_ready <= 1'b0;
      endcase
    end
  end

  //////////////////// read data

  always_comb begin
    o_cpu_rdata = '0;
    if (ofs_in_range) begin
      if (region == REG_CONT) begin
        case (word_ofs)
          2'd0: o_cpu_rdata = {{(CPU_DW-KEY_W){1'b0}}, i_cont1_key};
          2'd1: o_cpu_rdata = {{(CPU_DW-KEY_W){1'b0}}, i_cont2_key};
          2'd2: o_cpu_rdata = {{(CPU_DW-KEY_W){1'b0}}, i_cont3_key};
          default: o_cpu_rdata = {{(CPU_DW-KEY_W){1'b0}}, i_cont4_key};
        endcase
      end else if (region == REG_CTRL && word_ofs == CTRL_OFS_CTRL) begin
        // mask words are write only
        o_cpu_rdata = {{(CPU_DW-CTRL_W){1'b0}}, i_c64_ctrl};
      end
    end
  end

endmodule

// ==== hdl/host_ctrl_regs.sv ====
////////////////////
// control word and keyboard mask registers
// also steers controller keys onto the two joystick ports
// and drives the emulator reset from the run bit
////////////////////

`timescale 1ns/100ps

module host_ctrl_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_reg_wr,
  input  logic [c64_host_pkg::CTRL_OFS_W-1:0] i_addr_ofs,
  input  logic [c64_host_pkg::CPU_DW-1:0]     i_wdata,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont1_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont2_key,
  output logic [c64_host_pkg::CTRL_W-1:0]     o_c64_ctrl,
  output logic                                o_c64_rst,
  output logic [c64_host_pkg::KBD_MASK_W-1:0] o_keyboard_mask,
  output logic [c64_host_pkg::JOY_W-1:0]      o_joystick1,
  output logic [c64_host_pkg::JOY_W-1:0]      o_joystick2
);

  import c64_host_pkg::*;

  logic [CTRL_W-1:0]     c64_ctrl;
  logic [KBD_MASK_W-1:0] kbd_mask;
  joy_src_t              joy1_src;
  joy_src_t              joy2_src;

  // low key bits map straight to the joystick lines
  function automatic logic [JOY_W-1:0] joy_pick(
    input joy_src_t         sel,
    input logic [KEY_W-1:0] key1,
    input logic [KEY_W-1:0] key2
  );
    case (sel)
      JOY_CONT1: joy_pick = key1[JOY_W-1:0];
      JOY_CONT2: joy_pick = key2[JOY_W-1:0];
      default:   joy_pick = '0;
    endcase
  endfunction

  //////////////////// registers

  always_ff @(posedge clk) begin
    if (rst) begin
      c64_ctrl <= '0;
      kbd_mask <= '0;
    end else if (i_reg_wr) begin
      case (i_addr_ofs)
        CTRL_OFS_CTRL:    c64_ctrl <= i_wdata[CTRL_W-1:0];
        CTRL_OFS_MASK_LO: kbd_mask[CPU_DW-1:0] <= i_wdata;
        CTRL_OFS_MASK_HI: kbd_mask[KBD_MASK_W-1:CPU_DW] <= i_wdata;
        // word 0 has no register
        default: ;
      endcase
    end
  end

  //////////////////// outputs

  assign joy1_src = joy_src_t'(c64_ctrl[CTRL_JOY1_LSB +: $bits(joy_src_t)]);
  assign joy2_src = joy_src_t'(c64_ctrl[CTRL_JOY2_LSB +: $bits(joy_src_t)]);

  assign o_joystick1     = joy_pick(joy1_src, i_cont1_key, i_cont2_key);
  assign o_joystick2     = joy_pick(joy2_src, i_cont1_key, i_cont2_key);

  // emulator held in reset until run is set
  assign o_c64_rst       = ~c64_ctrl[CTRL_RUN_BIT];
  assign o_c64_ctrl      = c64_ctrl;
  assign o_keyboard_mask = kbd_mask;

endmodule

// ==== hdl/byte_loader.sv ====
////////////////////
// turns single byte cpu writes into c64 ram writes
// the write is held from ph2 until the next ph1 so the
// ram sees a stable access for the whole phase
////////////////////

`timescale 1ns/100ps

module byte_loader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                i_loader_wr,
  input  logic                                i_ph1_en,
  input  logic                                i_ph2_en,
  input  logic [c64_host_pkg::CPU_AW-1:0]     i_cpu_addr,
  input  logic [c64_host_pkg::CPU_DW-1:0]     i_cpu_wdata,
  input  logic [c64_host_pkg::CPU_STRB_W-1:0] i_cpu_wstrb,
  output logic                                o_ram_we,
  output logic [c64_host_pkg::C64_AW-1:0]     o_ram_addr,
  output logic [c64_host_pkg::C64_DW-1:0]     o_ram_wdata,
  output logic                                o_done
);

  import c64_host_pkg::*;

  logic hold;

  //////////////////// lane extraction

  // only a one-hot strobe selects a lane
  always_comb begin
    o_ram_addr  = '0;
    o_ram_wdata = '0;
    for (int k = 0; k < CPU_STRB_W; k++) begin
      if (i_cpu_wstrb == (CPU_STRB_W'(1) << k)) begin
        o_ram_addr  = {i_cpu_addr[C64_AW-1:CPU_LANE_W], CPU_LANE_W'(k)};
        o_ram_wdata = i_cpu_wdata[k*C64_DW +: C64_DW];
      end
    end
  end

  //////////////////// phase hold

  always_ff @(posedge clk) begin
    if (rst) begin
      hold <= 1'b0;
    end else if (i_ph2_en) begin
      hold <= i_loader_wr;
    end else if (i_ph1_en) begin
      hold <= 1'b0;
    end
  end

  // bus data stays put until ready, so it is stable under hold
  assign o_ram_we = hold;
  assign o_done   = hold & i_ph1_en;

endmodule

// ==== hdl/c64_main_ram.sv ====
////////////////////
// 64 KB c64 main memory, one port
// the loader owns the port while it writes
////////////////////

`timescale 1ns/100ps

module c64_main_ram (
  input  logic                            clk,
  input  logic                            i_ld_we,
  input  logic [c64_host_pkg::C64_AW-1:0] i_ld_addr,
  input  logic [c64_host_pkg::C64_DW-1:0] i_ld_wdata,
  input  logic [c64_host_pkg::C64_AW-1:0] i_c64_addr,
  input  logic                            i_c64_we,
  input  logic [c64_host_pkg::C64_DW-1:0] i_c64_wdata,
  output logic [c64_host_pkg::C64_DW-1:0] o_rdata
);

  import c64_host_pkg::*;

  logic [C64_DW-1:0] mem [0:(2**C64_AW)-1];
  logic [C64_AW-1:0] addr;
  logic [C64_DW-1:0] wdata;
  logic              we;

  // c64 access is dropped while the loader writes
  assign addr  = i_ld_we ? i_ld_addr : i_c64_addr;
  assign wdata = i_ld_we ? i_ld_wdata : i_c64_wdata;
  assign we    = i_ld_we | i_c64_we;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    o_rdata <= mem[addr];
  end

endmodule

// ==== hdl/c64_host_top.sv ====
////////////////////
// top of the C64 host fabric
// connects the bus decode, control registers,
// byte loader and c64 main ram
////////////////////

`timescale 1ns/100ps

module c64_host_top (
  input  logic                                clk,
  input  logic                                rst,
  // cpu native bus
  input  logic                                i_cpu_valid,
  input  logic [c64_host_pkg::CPU_AW-1:0]     i_cpu_addr,
  input  logic [c64_host_pkg::CPU_DW-1:0]     i_cpu_wdata,
  input  logic [c64_host_pkg::CPU_STRB_W-1:0] i_cpu_wstrb,
  output logic                                o_cpu_ready,
  output logic [c64_host_pkg::CPU_DW-1:0]     o_cpu_rdata,
  // c64 side
  input  logic                                i_ph1_en,
  input  logic                                i_ph2_en,
  input  logic [c64_host_pkg::C64_AW-1:0]     i_c64_addr,
  input  logic                                i_c64_we,
  input  logic [c64_host_pkg::C64_DW-1:0]     i_c64_wdata,
  output logic [c64_host_pkg::C64_DW-1:0]     o_c64_rdata,
  output logic                                o_c64_rst,
  output logic [c64_host_pkg::JOY_W-1:0]      o_joystick1,
  output logic [c64_host_pkg::JOY_W-1:0]      o_joystick2,
  output logic [c64_host_pkg::KBD_MASK_W-1:0] o_keyboard_mask,
  // controllers
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont1_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont2_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont3_key,
  input  logic [c64_host_pkg::KEY_W-1:0]      i_cont4_key
);

  import c64_host_pkg::*;

  logic              reg_wr;
  logic              loader_wr;
  logic              loader_done;
  logic [CTRL_W-1:0] c64_ctrl;
  logic              ram_we;
  logic [C64_AW-1:0] ram_addr;
  logic [C64_DW-1:0] ram_wdata;

  host_bus_decode host_bus_decode_i (
    .clk           (clk),
    .rst           (rst),
    .i_cpu_valid   (i_cpu_valid),
    .i_cpu_addr    (i_cpu_addr),
    .i_cpu_wstrb   (i_cpu_wstrb),
    .i_cont1_key   (i_cont1_key),
    .i_cont2_key   (i_cont2_key),
    .i_cont3_key   (i_cont3_key),
    .i_cont4_key   (i_cont4_key),
    .i_c64_ctrl    (c64_ctrl),
    .i_loader_done (loader_done),
    .o_cpu_ready   (o_cpu_ready),
    .o_cpu_rdata   (o_cpu_rdata),
    .o_reg_wr      (reg_wr),
    .o_loader_wr   (loader_wr)
  );

  host_ctrl_regs host_ctrl_regs_i (
    .clk             (clk),
    .rst             (rst),
    .i_reg_wr        (reg_wr),
    .i_addr_ofs      (i_cpu_addr[CPU_LANE_W +: CTRL_OFS_W]),
    .i_wdata         (i_cpu_wdata),
    .i_cont1_key     (i_cont1_key),
    .i_cont2_key     (i_cont2_key),
    .o_c64_ctrl      (c64_ctrl),
    .o_c64_rst       (o_c64_rst),
    .o_keyboard_mask (o_keyboard_mask),
    .o_joystick1     (o_joystick1),
    .o_joystick2     (o_joystick2)
  );

  byte_loader byte_loader_i (
    .clk         (clk),
    .rst         (rst),
    .i_loader_wr (loader_wr),
    .i_ph1_en    (i_ph1_en),
    .i_ph2_en    (i_ph2_en),
    .i_cpu_addr  (i_cpu_addr),
    .i_cpu_wdata (i_cpu_wdata),
    .i_cpu_wstrb (i_cpu_wstrb),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata),
    .o_done      (loader_done)
  );

  c64_main_ram c64_main_ram_i (
    .clk         (clk),
    .i_ld_we     (ram_we),
    .i_ld_addr   (ram_addr),
    .i_ld_wdata  (ram_wdata),
    .i_c64_addr  (i_c64_addr),
    .i_c64_we    (i_c64_we),
    .i_c64_wdata (i_c64_wdata),
    .o_rdata     (o_c64_rdata)
  );

endmodule

// ==== test/tb_c64_host.sv ====
////////////////////
// testbench for the C64 host fabric
// drives the cpu bus and the c64 port, models the expected
// registers and ram bytes, and compares in a separate process
////////////////////

`timescale 1ns/100ps

module tb_c64_host;

  localparam int READY_TIMEOUT = 40;
  localparam int DRAIN_TIMEOUT = 8;
  localparam int EXP_READ = 0;
  localparam int EXP_JOY1 = 1;
  localparam int EXP_JOY2 = 2;
  localparam int EXP_RST  = 3;
  localparam int EXP_MASK = 4;
  localparam int EXP_RAM  = 5;

  logic        clk;
  logic        rst;
  logic        i_cpu_valid;
  logic [31:0] i_cpu_addr;
  logic [31:0] i_cpu_wdata;
  logic [3:0]  i_cpu_wstrb;
  logic        o_cpu_ready;
  logic [31:0] o_cpu_rdata;
  logic        i_ph1_en;
  logic        i_ph2_en;
  logic [15:0] i_c64_addr;
  logic        i_c64_we;
  logic [7:0]  i_c64_wdata;
  logic [7:0]  o_c64_rdata;
  logic        o_c64_rst;
  logic [4:0]  o_joystick1;
  logic [4:0]  o_joystick2;
  logic [63:0] o_keyboard_mask;
  logic [15:0] i_cont1_key;
  logic [15:0] i_cont2_key;
  logic [15:0] i_cont3_key;
  logic [15:0] i_cont4_key;

  // reference model state
  logic [4:0]  m_ctrl;
  logic [63:0] m_mask;
  logic [15:0] m_keys [0:3];
  logic [7:0]  m_mem [logic [15:0]];

  // checks waiting for the comparing process
  string       chk_name [$];
  logic [63:0] chk_exp [$];
  logic [63:0] chk_act [$];

  logic [31:0] lfsr_state = 32'h51c0;
  logic        timed_out;
  int          checks;
  int          errors;
  int          tests;
  int          test_checks0;
  int          test_errors0;

  c64_host_top c64_host_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ph2 every 8 cycles and ph1 halfway between
  initial begin : phase_gen
    int cnt;
    cnt = 0;
    i_ph2_en <= 1'b0;
    i_ph1_en <= 1'b0;
    forever begin
      @(posedge clk);
      i_ph2_en <= (cnt == 0);
      i_ph1_en <= (cnt == 4);
      cnt = (cnt + 1) % 8;
    end
  end

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  //////////////////// reference model

  function automatic logic [63:0] expected_value(input int kind, input logic [31:0] addr);
    logic [1:0]  sel;
    logic [63:0] v;
    v = '0;
    case (kind)
      EXP_READ: begin
        if (addr[31:28] == 4'h2 && addr[27:4] == 24'h0) begin
          v = 64'(m_keys[addr[3:2]]);
        end else if (addr[31:28] == 4'h3 && addr[27:4] == 24'h0 && addr[3:2] == 2'd3) begin
          v = 64'(m_ctrl);
        end
      end
      EXP_JOY1, EXP_JOY2: begin
        sel = (kind == EXP_JOY1) ? m_ctrl[2:1] : m_ctrl[4:3];
        if (sel == 2'd1) begin
          v = 64'(m_keys[0][4:0]);
        end else if (sel == 2'd2) begin
          v = 64'(m_keys[1][4:0]);
        end
      end
      EXP_RST:  v = {63'd0, ~m_ctrl[0]};
      EXP_MASK: v = m_mask;
      EXP_RAM: begin
        if (m_mem.exists(addr[15:0])) begin
          v = 64'(m_mem[addr[15:0]]);
        end
      end
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] strb);
    logic hit;
    hit = 1'b0;
    if (addr[31:16] == 16'h5000) begin
      for (int k = 0; k < 4; k++) begin
        if (strb == (4'b1 << k)) begin
          m_mem[{addr[15:2], 2'(k)}] = wdata[8*k +: 8];
          hit = 1'b1;
        end
      end
      // other strobe patterns write 0 to address 0
      if (!hit && strb != 4'h0) begin
        m_mem[16'h0] = 8'h0;
      end
    end else if (addr[31:28] == 4'h3 && addr[27:4] == 24'h0 && strb == 4'hf) begin
      case (addr[3:2])
        2'd1: m_mask[31:0] = wdata;
        2'd2: m_mask[63:32] = wdata;
        2'd3: m_ctrl = wdata[4:0];
        default: ;
      endcase
    end
  endfunction

  //////////////////// comparing process

  always @(negedge clk) begin : compare
    string       nm;
    logic [63:0] e;
    logic [63:0] a;
    while (chk_name.size() > 0) begin
      nm = chk_name.pop_front();
      e = chk_exp.pop_front();
      a = chk_act.pop_front();
      checks++;
      assert (e === a) else begin
        $display("ERROR %s expected 0x%0h actual 0x%0h", nm, e, a);
        errors++;
      end
    end
  end

  task automatic post_check(input string name, input logic [63:0] e, input logic [63:0] a);
    chk_name.push_back(name);
    chk_exp.push_back(e);
    chk_act.push_back(a);
  endtask

  task automatic start_test();
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic end_test(input string name);
    int cnt;
    cnt = 0;
    while (chk_name.size() > 0 && cnt < DRAIN_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (chk_name.size() > 0) begin
      $display("comparing process did not take the pending checks of %s", name);
      timed_out = 1'b1;
    end
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks0,
             errors - test_errors0);
  endtask

  //////////////////// bus and port tasks

  task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output int latency);
    int cnt;
    rdata = '0;
    latency = 0;
    if (!timed_out) begin
      @(posedge clk);
      i_cpu_valid <= 1'b1;
      i_cpu_addr  <= addr;
      i_cpu_wdata <= wdata;
      i_cpu_wstrb <= strb;
      @(negedge clk);
      cnt = 1;
      while (!o_cpu_ready && cnt < READY_TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (o_cpu_ready) begin
        rdata = o_cpu_rdata;
        latency = cnt - 1;
        model_write(addr, wdata, strb);
      end else begin
        $display("timeout waiting for cpu ready at address 0x%08h", addr);
        timed_out = 1'b1;
      end
      @(posedge clk);
      i_cpu_valid <= 1'b0;
      i_cpu_wstrb <= '0;
    end
  endtask

  // registered read with data one cycle after the address
  task automatic c64_read(input logic [15:0] a, output logic [7:0] d);
    @(posedge clk);
    i_c64_addr <= a;
    @(posedge clk);
    @(negedge clk);
    d = o_c64_rdata;
  endtask

  task automatic set_keys();
    logic [31:0] r;
    logic [15:0] k [0:3];
    for (int i = 0; i < 4; i++) begin
      r = rand_bits(16);
      k[i] = r[15:0];
      m_keys[i] = k[i];
    end
    @(posedge clk);
    i_cont1_key <= k[0];
    i_cont2_key <= k[1];
    i_cont3_key <= k[2];
    i_cont4_key <= k[3];
  endtask

  task automatic check_outputs(input string tag);
    @(negedge clk);
    post_check({tag, "_rst"}, expected_value(EXP_RST, 0), {63'd0, o_c64_rst});
    post_check({tag, "_joy1"}, expected_value(EXP_JOY1, 0), 64'(o_joystick1));
    post_check({tag, "_joy2"}, expected_value(EXP_JOY2, 0), 64'(o_joystick2));
    post_check({tag, "_mask"}, expected_value(EXP_MASK, 0), o_keyboard_mask);
  endtask

  //////////////////// stimulus

  initial begin : stimulus
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wd;
    logic [7:0]  byte_rd;
    logic [3:0]  c4;
    logic [1:0]  lane;
    int          lat;
    logic [15:0] ld_addr [$];

    timed_out = 1'b0;
    checks = 0;
    errors = 0;
    tests = 0;
    m_ctrl = '0;
    m_mask = '0;
    for (int i = 0; i < 4; i++) begin
      m_keys[i] = '0;
    end
    rst <= 1'b1;
    i_cpu_valid <= 1'b0;
    i_cpu_addr <= '0;
    i_cpu_wdata <= '0;
    i_cpu_wstrb <= '0;
    i_c64_addr <= '0;
    i_c64_we <= 1'b0;
    i_c64_wdata <= '0;
    i_cont1_key <= '0;
    i_cont2_key <= '0;
    i_cont3_key <= '0;
    i_cont4_key <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    start_test();
    check_outputs("reset");
    cpu_access(32'h3000_000C, '0, 4'h0, rd, lat);
    post_check("reset_ctrl_read", expected_value(EXP_READ, 32'h3000_000C), 64'(rd));
    end_test("after_reset");

    start_test();
    for (int pass = 0; pass < 2; pass++) begin
      set_keys();
      for (int ofs = 0; ofs < 4; ofs++) begin
        addr = 32'h2000_0000 | (32'(ofs) << 2);
        cpu_access(addr, '0, 4'h0, rd, lat);
        post_check("cont_read", expected_value(EXP_READ, addr), 64'(rd));
        post_check("cont_ready_latency", 64'd1, 64'(lat));
      end
    end
    end_test("controller_reads");

    start_test();
    for (int code = 0; code < 16; code++) begin
      set_keys();
      c4 = 4'(code);
      r = rand_bits(28);
      wd = {r[26:0], c4, r[27]};
      cpu_access(32'h3000_000C, wd, 4'hf, rd, lat);
      post_check("ctrl_ready_latency", 64'd1, 64'(lat));
      cpu_access(32'h3000_000C, '0, 4'h0, rd, lat);
      post_check("ctrl_readback", expected_value(EXP_READ, 32'h3000_000C), 64'(rd));
      check_outputs("ctrl");
    end
    end_test("control_word");

    start_test();
    cpu_access(32'h3000_0004, rand_bits(32), 4'hf, rd, lat);
    cpu_access(32'h3000_0008, rand_bits(32), 4'hf, rd, lat);
    check_outputs("mask_full");
    // partial strobes leave every register alone
    cpu_access(32'h3000_0004, rand_bits(32), 4'h3, rd, lat);
    cpu_access(32'h3000_0008, rand_bits(32), 4'h8, rd, lat);
    cpu_access(32'h3000_000C, rand_bits(32), 4'he, rd, lat);
    check_outputs("mask_partial");
    cpu_access(32'h3000_000C, '0, 4'h0, rd, lat);
    post_check("mask_partial_ctrl", expected_value(EXP_READ, 32'h3000_000C), 64'(rd));
    end_test("keyboard_mask");

    start_test();
    for (int n = 0; n < 12; n++) begin
      r = rand_bits(16);
      lane = 2'(rand_bits(2));
      addr = {16'h5000, r[15:0]};
      cpu_access(addr, rand_bits(32), 4'b1 << lane, rd, lat);
      ld_addr.push_back({r[15:2], lane});
    end
    foreach (ld_addr[i]) begin
      c64_read(ld_addr[i], byte_rd);
      post_check("loader_byte", expected_value(EXP_RAM, {16'h0, ld_addr[i]}), 64'(byte_rd));
    end
    end_test("loader_writes");

    $display("summary: %0d tests, %0d checks, %0d errors, timeout %0d", tests, checks,
             errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/c64_host_pkg.sv
hdl/host_bus_decode.sv
hdl/host_ctrl_regs.sv
hdl/byte_loader.sv
hdl/c64_main_ram.sv
hdl/c64_host_top.sv
test/tb_c64_host.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_c64_host \
  -Mdir obj_dir -o tb_c64_host
./obj_dir/tb_c64_host > sim.log
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
